//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

  localparam int WORD_W = 16;
  localparam int NUM_REGS = 8;
  localparam int REG_W = $clog2(NUM_REGS);

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0] reg_num_t;

  // Shift and rotate amounts come from the low nibble of B
  typedef enum logic [2:0] {
    op_rol = 3'd0,
    op_sll = 3'd1,
    op_sra = 3'd2,
    op_srl = 3'd3,
    op_add = 3'd4,
    op_and = 3'd5,
    op_or  = 3'd6,
    op_xor = 3'd7
  } alu_op_t;

  typedef enum logic [2:0] {
    src1_rs      = 3'd0,
    src1_rs_shl8 = 3'd1,
    src1_imm5    = 3'd2,
    src1_imm8    = 3'd3,
    src1_rt      = 3'd4,
    src1_zero    = 3'd5
  } src1_sel_t;

  // Rotate amounts are sixteen minus the low nibble
  typedef enum logic [2:0] {
    src2_rt       = 3'd0,
    src2_imm5     = 3'd1,
    src2_imm8     = 3'd2,
    src2_rs       = 3'd3,
    src2_zero     = 3'd4,
    src2_rot_rt   = 3'd5,
    src2_rot_imm5 = 3'd6
  } src2_sel_t;

  // Instruction bits 12..11
  typedef enum logic [1:0] {
    cond_seq = 2'd0,
    cond_slt = 2'd1,
    cond_sle = 2'd2,
    cond_sco = 2'd3
  } cond_t;

  typedef enum logic [1:0] {
    fwd_reg   = 2'd0,
    fwd_exmem = 2'd1,
    fwd_memwb = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    alu_op_t   op;
    logic      cin;
    logic      inv_a;
    logic      inv_b;
    logic      sign;
    logic      use_set;
    logic      reg_write;
    reg_num_t  dst;
  } ex_ctrl_t;

  typedef struct packed {
    word_t    instr;
    word_t    rs_data;
    word_t    rt_data;
    word_t    imm5;
    word_t    imm8;
    ex_ctrl_t ctrl;
  } ex_issue_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_num_t dst;
    word_t    value;
  } ex_result_t;

endpackage

`default_nettype wire

//--- hdl/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
  input  ex_pkg::word_t      instr,
  input  ex_pkg::ex_result_t exmem,
  input  ex_pkg::ex_result_t memwb,
  output ex_pkg::fwd_sel_t   fwd_a,
  output ex_pkg::fwd_sel_t   fwd_b
);

  import ex_pkg::*;

  reg_num_t rs;
  reg_num_t rt;

  // Newest matching writer wins
  function automatic fwd_sel_t pick(reg_num_t src, ex_result_t em, ex_result_t mw);
    if (em.valid && em.reg_write && em.dst == src) begin
      return fwd_exmem;
    end
    if (mw.valid && mw.reg_write && mw.dst == src) begin
      return fwd_memwb;
    end
    return fwd_reg;
  endfunction

  assign rs = instr[10:8];
  assign rt = instr[7:5];

  assign fwd_a = pick(rs, exmem, memwb);
  assign fwd_b = pick(rt, exmem, memwb);

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
  input  ex_pkg::ex_issue_t issue,
  input  ex_pkg::fwd_sel_t  fwd_a,
  input  ex_pkg::fwd_sel_t  fwd_b,
  input  ex_pkg::word_t     exmem_value,
  input  ex_pkg::word_t     memwb_value,
  output ex_pkg::word_t     src_a,
  output ex_pkg::word_t     src_b
);

  import ex_pkg::*;

  word_t rs_fresh;
  word_t rt_fresh;
  word_t rs_shl8;
  word_t rot_rt;
  word_t rot_imm5;

  // Fresh register values before any operand selection
  always_comb begin
    case (fwd_a)
      fwd_exmem: rs_fresh = exmem_value;
      fwd_memwb: rs_fresh = memwb_value;
      default:   rs_fresh = issue.rs_data;
    endcase
    case (fwd_b)
      fwd_exmem: rt_fresh = exmem_value;
      fwd_memwb: rt_fresh = memwb_value;
      default:   rt_fresh = issue.rt_data;
    endcase
  end

  assign rs_shl8 = rs_fresh << 8;

  // Rotate right by n is rotate left by 16 - n
  assign rot_rt   = word_t'(WORD_W) - word_t'(rt_fresh[3:0]);
  assign rot_imm5 = word_t'(WORD_W) - word_t'(issue.imm5[3:0]);

  always_comb begin
    case (issue.ctrl.src1_sel)
      src1_rs:      src_a = rs_fresh;
      src1_rs_shl8: src_a = rs_shl8;
      src1_imm5:    src_a = issue.imm5;
      src1_imm8:    src_a = issue.imm8;
      src1_rt:      src_a = rt_fresh;
      default:      src_a = '0;
    endcase
  end

  always_comb begin
    case (issue.ctrl.src2_sel)
      src2_rt:       src_b = rt_fresh;
      src2_imm5:     src_b = issue.imm5;
      src2_imm8:     src_b = issue.imm8;
      src2_rs:       src_b = rs_fresh;
      src2_rot_rt:   src_b = rot_rt;
      src2_rot_imm5: src_b = rot_imm5;
      default:       src_b = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  ex_pkg::word_t   a,
  input  ex_pkg::word_t   b,
  input  ex_pkg::alu_op_t op,
  input  logic            cin,
  input  logic            inv_a,
  input  logic            inv_b,
  input  logic            sign,
  output ex_pkg::word_t   out,
  output logic            zero,
  output logic            cout,
  output logic            ofl
);

  import ex_pkg::*;

  word_t                 a_in;
  word_t                 b_in;
  logic [3:0]            amt;
  logic [2*WORD_W-1:0]   rot_full;
  logic [WORD_W:0]       sum;
  logic                  add_ofl;

  assign a_in = inv_a ? ~a : a;
  assign b_in = inv_b ? ~b : b;
  assign amt  = b_in[3:0];

  // Upper half of the doubled word holds the rotated value
  assign rot_full = {a_in, a_in} << amt;

  assign sum = {1'b0, a_in} + {1'b0, b_in} + {{WORD_W{1'b0}}, cin};

  // Signed overflow when like-signed operands give a differently signed sum
  always_comb begin
    if (sign) begin
      add_ofl = (a_in[WORD_W-1] == b_in[WORD_W-1]) &&
                (sum[WORD_W-1] != a_in[WORD_W-1]);
    end else begin
      add_ofl = sum[WORD_W];
    end
  end

  always_comb begin
    cout = 1'b0;
    ofl  = 1'b0;
    case (op)
      op_rol: out = rot_full[2*WORD_W-1:WORD_W];
      op_sll: out = a_in << amt;
      op_sra: out = word_t'($signed(a_in) >>> amt);
      op_srl: out = a_in >> amt;
      op_add: begin
        out  = sum[WORD_W-1:0];
        cout = sum[WORD_W];
        ofl  = add_ofl;
      end
      op_and: out = a_in & b_in;
      op_or:  out = a_in | b_in;
      default: out = a_in ^ b_in;
    endcase
  end

  assign zero = (out == '0);

endmodule

`default_nettype wire

//--- hdl/cond_set.sv
`timescale 1ns/1ps
`default_nettype none

// Flags come from A minus B (or A plus B for sco) as set up by decode
module cond_set (
  input  ex_pkg::cond_t cond,
  input  logic          zero,
  input  logic          cout,
  input  logic          a_msb,
  input  logic          b_msb,
  input  logic          out_msb,
  output ex_pkg::word_t set
);

  import ex_pkg::*;

  logic lt;
  logic hit;

  // Differing signs decide directly, so overflow cannot mislead
  assign lt = (a_msb != b_msb) ? a_msb : out_msb;

  always_comb begin
    case (cond)
      cond_seq: hit = zero;
      cond_slt: hit = lt;
      cond_sle: hit = lt | zero;
      default:  hit = cout;
    endcase
  end

  assign set = word_t'(hit);

endmodule

`default_nettype wire

//--- hdl/execution.sv
`timescale 1ns/1ps
`default_nettype none

module execution (
  input  ex_pkg::ex_issue_t  issue,
  input  ex_pkg::ex_result_t exmem,
  input  ex_pkg::ex_result_t memwb,
  output ex_pkg::word_t      value
);

  import ex_pkg::*;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  word_t    src_a;
  word_t    src_b;
  word_t    alu_out;
  logic     zero;
  logic     cout;
  word_t    set;

  forward_unit u_forward_unit (
    .instr (issue.instr),
    .exmem (exmem),
    .memwb (memwb),
    .fwd_a (fwd_a),
    .fwd_b (fwd_b)
  );

  operand_select u_operand_select (
    .issue       (issue),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .exmem_value (exmem.value),
    .memwb_value (memwb.value),
    .src_a       (src_a),
    .src_b       (src_b)
  );

  alu u_alu (
    .a     (src_a),
    .b     (src_b),
    .op    (issue.ctrl.op),
    .cin   (issue.ctrl.cin),
    .inv_a (issue.ctrl.inv_a),
    .inv_b (issue.ctrl.inv_b),
    .sign  (issue.ctrl.sign),
    .out   (alu_out),
    .zero  (zero),
    .cout  (cout),
    .ofl   ()
  );

  cond_set u_cond_set (
    .cond    (cond_t'(issue.instr[12:11])),
    .zero    (zero),
    .cout    (cout),
    .a_msb   (src_a[WORD_W-1]),
    .b_msb   (src_b[WORD_W-1]),
    .out_msb (alu_out[WORD_W-1]),
    .set     (set)
  );

  assign value = issue.ctrl.use_set ? set : alu_out;

endmodule

`default_nettype wire

//--- hdl/ex_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               issue_valid,
  input  ex_pkg::ex_issue_t  issue,
  output ex_pkg::ex_result_t exmem,
  output ex_pkg::ex_result_t memwb
);

  import ex_pkg::*;

  word_t value;

  execution u_execution (
    .issue (issue),
    .exmem (exmem),
    .memwb (memwb),
    .value (value)
  );

  // EX/MEM takes the issue cycle's result, bubbles clear valid and write
  always_ff @(posedge clk) begin
    if (reset) begin
      exmem <= '0;
    end else begin
      exmem.valid     <= issue_valid;
      exmem.reg_write <= issue_valid & issue.ctrl.reg_write;
      exmem.dst       <= issue.ctrl.dst;
      exmem.value     <= value;
    end
  end

  // No data memory, so MEM/WB is EX/MEM delayed by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      memwb <= '0;
    end else begin
      memwb <= exmem;
    end
  end

endmodule

`default_nettype wire

//--- test/ex_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_checker (
  input logic               clk,
  input logic               reset,
  input logic               issue_valid,
  input ex_pkg::ex_result_t exmem,
  input ex_pkg::ex_result_t memwb,
  input ex_pkg::fwd_sel_t   fwd_a,
  input ex_pkg::fwd_sel_t   fwd_b
);

  import ex_pkg::*;

  a_reset_clears: assert property (@(posedge clk) reset |=> (!exmem.valid && !memwb.valid))
    else $error("result register valid while reset is held");

  a_release_clears: assert property (@(posedge clk) $fell(reset) |=> !memwb.valid)
    else $error("memwb valid one cycle after reset release");

  a_memwb_follows: assert property (@(posedge clk) disable iff (reset)
    memwb.valid == $past(exmem.valid))
    else $error("memwb valid does not follow exmem valid");

  // Encoding 3 is not a forwarding source
  a_fwd_legal: assert property (@(posedge clk) disable iff (reset)
    (fwd_a != 2'd3) && (fwd_b != 2'd3))
    else $error("forwarding select took the unused encoding");

  a_bubble_no_write: assert property (@(posedge clk) disable iff (reset)
    !issue_valid |=> !exmem.reg_write)
    else $error("bubble left reg_write set in exmem");

endmodule

bind ex_pipe ex_pipe_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .issue_valid (issue_valid),
  .exmem       (exmem),
  .memwb       (memwb),
  .fwd_a       (u_execution.fwd_a),
  .fwd_b       (u_execution.fwd_b)
);

`default_nettype wire

//--- test/ex_pipe_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_monitor (
  input  logic               clk,
  input  ex_pkg::ex_result_t exmem,
  input  ex_pkg::ex_result_t memwb,
  input  logic               row_active,
  input  int                 row_index,
  input  logic               row_valid,
  input  ex_pkg::word_t      row_expected,
  output int                 pass_count,
  output int                 fail_count
);

  import ex_pkg::*;

  logic  pend_active = 1'b0;
  int    pend_index = 0;
  logic  pend_valid = 1'b0;
  word_t pend_expected = '0;
  logic  pend_bad = 1'b0;
  logic  late_active = 1'b0;
  int    late_index = 0;
  logic  late_valid = 1'b0;
  word_t late_expected = '0;
  logic  late_bad = 1'b0;
  logic  row_bad = 1'b0;
  int    passes = 0;
  int    fails = 0;

  assign pass_count = passes;
  assign fail_count = fails;

  // Row info follows the row through EX/MEM and then MEM/WB
  always @(posedge clk) begin
    pend_active   <= row_active;
    pend_index    <= row_index;
    pend_valid    <= row_valid;
    pend_expected <= row_expected;
    late_active   <= pend_active;
    late_index    <= pend_index;
    late_valid    <= pend_valid;
    late_expected <= pend_expected;
    late_bad      <= pend_bad;
  end

  // Both result registers are stable at the falling edge
  always @(negedge clk) begin
    pend_bad = 1'b0;
    if (pend_active) begin
      if (exmem.valid !== pend_valid) begin
        $display("CHECK FAILED time %0t row %0d signal exmem.valid got %0b expected %0b",
                 $time, pend_index, exmem.valid, pend_valid);
        pend_bad = 1'b1;
      end else if (pend_valid && (exmem.value !== pend_expected)) begin
        $display("CHECK FAILED time %0t row %0d signal exmem.value got %h expected %h",
                 $time, pend_index, exmem.value, pend_expected);
        pend_bad = 1'b1;
      end
    end
    if (late_active) begin
      row_bad = late_bad;
      if (memwb.valid !== late_valid) begin
        $display("CHECK FAILED time %0t row %0d signal memwb.valid got %0b expected %0b",
                 $time, late_index, memwb.valid, late_valid);
        row_bad = 1'b1;
      end else if (late_valid && (memwb.value !== late_expected)) begin
        $display("CHECK FAILED time %0t row %0d signal memwb.value got %h expected %h",
                 $time, late_index, memwb.value, late_expected);
        row_bad = 1'b1;
      end
      if (row_bad) begin
        fails = fails + 1;
      end else begin
        $display("row %0d passed at %0t", late_index, $time);
        passes = passes + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/ex_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_tb;

  import ex_pkg::*;

  localparam int NUM_ROWS = 22;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 10;

  logic       clk = 1'b0;
  logic       reset;
  logic       issue_valid;
  ex_issue_t  issue;
  ex_result_t exmem;
  ex_result_t memwb;

  logic  row_active;
  int    row_index;
  logic  row_valid;
  word_t row_expected;
  int    pass_count;
  int    fail_count;
  int    other_errors = 0;
  int    cycle_count = 0;
  int    fill_count = 0;

  logic      valid_tbl [NUM_ROWS];
  ex_issue_t issue_tbl [NUM_ROWS];
  word_t     expected_tbl [NUM_ROWS];

  always #4 clk = ~clk;

  ex_pipe DUT (
    .clk         (clk),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue       (issue),
    .exmem       (exmem),
    .memwb       (memwb)
  );

  ex_pipe_monitor u_monitor (
    .clk          (clk),
    .exmem        (exmem),
    .memwb        (memwb),
    .row_active   (row_active),
    .row_index    (row_index),
    .row_valid    (row_valid),
    .row_expected (row_expected),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  // Mode bits are use_set, cin, inv_a, inv_b, sign
  function automatic ex_ctrl_t ctrl_of(src1_sel_t s1, src2_sel_t s2, alu_op_t op,
                                       logic [4:0] mode, logic rw, reg_num_t dst);
    ex_ctrl_t c;
    c.src1_sel  = s1;
    c.src2_sel  = s2;
    c.op        = op;
    {c.use_set, c.cin, c.inv_a, c.inv_b, c.sign} = mode;
    c.reg_write = rw;
    c.dst       = dst;
    return c;
  endfunction

  task automatic add_row(logic valid, reg_num_t rs, reg_num_t rt, cond_t cond,
                         word_t rs_data, word_t rt_data, word_t imm5, word_t imm8,
                         ex_ctrl_t ctrl, word_t expected);
    valid_tbl[fill_count]         = valid;
    issue_tbl[fill_count].instr   = {3'b000, cond, rs, rt, 5'b00000};
    issue_tbl[fill_count].rs_data = rs_data;
    issue_tbl[fill_count].rt_data = rt_data;
    issue_tbl[fill_count].imm5    = imm5;
    issue_tbl[fill_count].imm8    = imm8;
    issue_tbl[fill_count].ctrl    = ctrl;
    expected_tbl[fill_count]      = expected;
    fill_count = fill_count + 1;
  endtask

  task automatic fill_table();
    // Independent ALU operations and source selects
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h1234, 16'h0F0F, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b00000, 1'b0, 3'd0), 16'h2143);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0005, 16'h0007, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b01011, 1'b0, 3'd0), 16'hFFFE);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'hF0F0, 16'h3C3C, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_and, 5'b00000, 1'b0, 3'd0), 16'h3030);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h00FF, 16'h0F0F, 16'h0000, 16'h0000,
            ctrl_of(src1_rt, src2_rs, op_xor, 5'b00000, 1'b0, 3'd0), 16'h0FF0);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0013, 16'h0004, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_sll, 5'b00000, 1'b0, 3'd0), 16'h0130);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0000, 16'h0004, 16'h0000, 16'hFF80,
            ctrl_of(src1_imm8, src2_rt, op_srl, 5'b00000, 1'b0, 3'd0), 16'h0FF8);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h8100, 16'h0004, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_sra, 5'b00000, 1'b0, 3'd0), 16'hF810);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h1234, 16'h0004, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_rol, 5'b00000, 1'b0, 3'd0), 16'h2341);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h00AB, 16'h0000, 16'h0000, 16'h0012,
            ctrl_of(src1_rs_shl8, src2_imm8, op_or, 5'b00000, 1'b0, 3'd0), 16'hAB12);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0000, 16'h0000, 16'hFFF5, 16'h0000,
            ctrl_of(src1_imm5, src2_zero, op_or, 5'b00000, 1'b0, 3'd0), 16'hFFF5);
    // Rotate right by 4 and by 1
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h1234, 16'h0004, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rot_rt, op_rol, 5'b00000, 1'b0, 3'd0), 16'h4123);
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h00F1, 16'h0000, 16'h0001, 16'h0000,
            ctrl_of(src1_rs, src2_rot_imm5, op_rol, 5'b00000, 1'b0, 3'd0), 16'h8078);
    // Compares with two overflowing differences
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0042, 16'h0042, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b11011, 1'b0, 3'd0), 16'h0001);
    add_row(1'b1, 3'd1, 3'd2, cond_slt, 16'h8000, 16'h0001, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b11011, 1'b0, 3'd0), 16'h0001);
    add_row(1'b1, 3'd1, 3'd2, cond_sle, 16'h7FFF, 16'hFFFF, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b11011, 1'b0, 3'd0), 16'h0000);
    add_row(1'b1, 3'd1, 3'd2, cond_sco, 16'hFFFF, 16'h0002, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b10000, 1'b0, 3'd0), 16'h0001);
    // Forwarding chain on r3 with 16'hDEAD as stale register data
    add_row(1'b1, 3'd1, 3'd2, cond_seq, 16'h0100, 16'h0023, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b00000, 1'b1, 3'd3), 16'h0123);
    add_row(1'b1, 3'd2, 3'd3, cond_seq, 16'h0001, 16'hDEAD, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b00000, 1'b1, 3'd3), 16'h0124);
    add_row(1'b1, 3'd3, 3'd6, cond_seq, 16'hDEAD, 16'h0F00, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_xor, 5'b00000, 1'b0, 3'd3), 16'h0E24);
    add_row(1'b1, 3'd3, 3'd5, cond_seq, 16'hDEAD, 16'h1000, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_or, 5'b00000, 1'b0, 3'd0), 16'h1124);
    // Bubble that would write r3 followed by a reader of r3
    add_row(1'b0, 3'd1, 3'd2, cond_seq, 16'h7000, 16'h0000, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b00000, 1'b1, 3'd3), 16'h0000);
    add_row(1'b1, 3'd3, 3'd2, cond_seq, 16'h0050, 16'h0005, 16'h0000, 16'h0000,
            ctrl_of(src1_rs, src2_rt, op_add, 5'b00000, 1'b0, 3'd0), 16'h0055);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with rows still unchecked", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    reset        = 1'b1;
    issue_valid  = 1'b0;
    issue        = '0;
    row_active   = 1'b0;
    row_index    = 0;
    row_valid    = 1'b0;
    row_expected = '0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    if (exmem.valid !== 1'b0 || memwb.valid !== 1'b0) begin
      $display("CHECK FAILED time %0t signal exmem.valid/memwb.valid got %0b/%0b expected 0/0",
               $time, exmem.valid, memwb.valid);
      other_errors = other_errors + 1;
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #1;
      issue_valid  = valid_tbl[i];
      issue        = issue_tbl[i];
      row_active   = 1'b1;
      row_index    = i;
      row_valid    = valid_tbl[i];
      row_expected = expected_tbl[i];
    end
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    row_active  = 1'b0;
    wait (pass_count + fail_count == NUM_ROWS);
    $display("Rows passed: %0d, rows failed: %0d, other errors: %0d",
             pass_count, fail_count, other_errors);
    if (fail_count == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/ex_pkg.sv
hdl/forward_unit.sv
hdl/operand_select.sv
hdl/alu.sv
hdl/cond_set.sv
hdl/execution.sv
hdl/ex_pipe.sv
test/ex_pipe_checker.sv
test/ex_pipe_monitor.sv
test/ex_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module ex_pipe_tb -f verilog.f -o ex_pipe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ex_pipe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
  exit 0
else
  exit 1
fi
